// ==== verilog/ks10_settings.svh ====
/*
 * KS10 bus settings
 * memory size, I/O windows, responder latencies and bus timeout
 */
`ifndef KS10_SETTINGS_SVH
`define KS10_SETTINGS_SVH

////////////////////////////////////////
// main memory
////////////////////////////////////////

// words of main memory, answered when the I/O flag is low
`define KS10_MEM_WORDS 1024

////////////////////////////////////////
// I/O address windows
////////////////////////////////////////

// console mailbox words
`define KS10_CONS_BASE  18'o200000
`define KS10_CONS_WORDS 4

// adapter register file
`define KS10_UBA_BASE  18'o763000
`define KS10_UBA_WORDS 16

////////////////////////////////////////
// acknowledge latencies in cycles
////////////////////////////////////////

`define KS10_MEM_LAT  2
`define KS10_CONS_LAT 1
`define KS10_UBA_LAT  3

// cycles without acknowledge before nonexistent memory
`define KS10_NXM_TIMEOUT 8

`endif

// ==== verilog/ks10Pkg.sv ====
/*
 * KS10 bus types
 * data word and physical address shared by the bus responders
 */
package ks10Pkg;

   ////////////////////////////////////////
   // data word
   ////////////////////////////////////////

   // one 36-bit word
   // bit 0 is the most significant bit, as on the KS10
   // bit 35 is the least significant bit
   typedef logic [0:35] ks10Word_t;

   ////////////////////////////////////////
   // address
   ////////////////////////////////////////

   // 18-bit physical or I/O address
   // same numbering as the data word
   // low order bits select a word inside a window
   typedef logic [0:17] ks10Addr_t;

   // memory space is selected with the I/O flag low
   // I/O space is selected with the I/O flag high
   // both spaces share this address type

endpackage

// ==== verilog/memCtrl.sv ====
/*
 * KS10 memory controller
 * main memory array with two-stage registered read and acknowledge
 */
`timescale 1ns/10ps
`include "ks10_settings.svh"

module memCtrl (
   input  logic               clk,
   input  logic               rstN,
   input  logic               busREQ,
   input  logic               busIO,
   input  logic               busWRITE,
   input  ks10Pkg::ks10Addr_t busADDR,
   input  ks10Pkg::ks10Word_t busDATA,
   output logic               memACK,
   output ks10Pkg::ks10Word_t memDATA
);
   import ks10Pkg::*;

   localparam int unsigned addrW = $bits(ks10Addr_t);
   localparam int unsigned memAw = $clog2(`KS10_MEM_WORDS);

   // storage, contents undefined after reset
   ks10Word_t        memArray [`KS10_MEM_WORDS];
   logic [memAw-1:0] memIdx;
   logic             memHit;
   logic             ackStage1;
   ks10Word_t        rdStage1;
   ks10Word_t        rdStage2;

   ////////////////////////////////////////
   // address decode
   ////////////////////////////////////////

   // word index from the low order address bits
   assign memIdx = busADDR[addrW-memAw:addrW-1];

   // memory space only, below the top of memory
   assign memHit = busREQ && !busIO && (busADDR < ks10Addr_t'(`KS10_MEM_WORDS));

   ////////////////////////////////////////
   // array and read word pipe
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      // write lands on the sampling edge
      if (memHit && busWRITE) begin
         memArray[memIdx] <= busDATA;
      end
      // write cycles carry a zero word
      if (memHit && !busWRITE) begin
         rdStage1 <= memArray[memIdx];
      end else begin
         rdStage1 <= '0;
      end
      rdStage2 <= rdStage1;
   end

   // valid bit follows the read word
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         ackStage1 <= 1'b0;
         memACK    <= 1'b0;
      end else begin
         ackStage1 <= memHit;
         memACK    <= ackStage1;
      end
   end

   // data held at zero outside the acknowledge
   assign memDATA = memACK ? rdStage2 : '0;

   // one request in flight means a single-cycle acknowledge
   memAckPulse: assert property (@(posedge clk) disable iff (!rstN) memACK |=> !memACK)
      else $error("memACK high in two consecutive cycles");

endmodule

// ==== verilog/consRegs.sv ====
/*
 * KS10 console registers
 * mailbox words in I/O space with a one-cycle acknowledge
 */
`timescale 1ns/10ps
`include "ks10_settings.svh"

module consRegs (
   input  logic               clk,
   input  logic               rstN,
   input  logic               busREQ,
   input  logic               busIO,
   input  logic               busWRITE,
   input  ks10Pkg::ks10Addr_t busADDR,
   input  ks10Pkg::ks10Word_t busDATA,
   output logic               consACK,
   output ks10Pkg::ks10Word_t consDATA
);
   import ks10Pkg::*;

   localparam int unsigned addrW  = $bits(ks10Addr_t);
   localparam int unsigned consAw = $clog2(`KS10_CONS_WORDS);

   ks10Word_t         mbox [`KS10_CONS_WORDS];
   logic [consAw-1:0] consIdx;
   logic              consHit;
   ks10Word_t         rdData;

   ////////////////////////////////////////
   // window decode
   ////////////////////////////////////////

   // window is aligned so the low bits pick the mailbox
   assign consIdx = busADDR[addrW-consAw:addrW-1];

   assign consHit = busREQ && busIO &&
                    (busADDR >= ks10Addr_t'(`KS10_CONS_BASE)) &&
                    (busADDR <  ks10Addr_t'(`KS10_CONS_BASE + `KS10_CONS_WORDS));

   ////////////////////////////////////////
   // mailbox words and acknowledge
   ////////////////////////////////////////

   // mailboxes read zero after reset
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < `KS10_CONS_WORDS; i++) begin
            mbox[i] <= '0;
         end
         consACK <= 1'b0;
      end else begin
         if (consHit && busWRITE) begin
            mbox[consIdx] <= busDATA;
         end
         consACK <= consHit;
      end
   end

   // read word, zero on a write
   always_ff @(posedge clk) begin
      rdData <= (consHit && !busWRITE) ? mbox[consIdx] : '0;
   end

   assign consDATA = consACK ? rdData : '0;

endmodule

// ==== verilog/ubaRegs.sv ====
/*
 * KS10 bus adapter registers
 * sixteen I/O registers behind a three-stage acknowledge delay
 */
`timescale 1ns/10ps
`include "ks10_settings.svh"

module ubaRegs (
   input  logic               clk,
   input  logic               rstN,
   input  logic               busREQ,
   input  logic               busIO,
   input  logic               busWRITE,
   input  ks10Pkg::ks10Addr_t busADDR,
   input  ks10Pkg::ks10Word_t busDATA,
   output logic               ubaACK,
   output ks10Pkg::ks10Word_t ubaDATA
);
   import ks10Pkg::*;

   localparam int unsigned addrW = $bits(ks10Addr_t);
   localparam int unsigned ubaAw = $clog2(`KS10_UBA_WORDS);

   ks10Word_t        ubaReg [`KS10_UBA_WORDS];
   logic [ubaAw-1:0] ubaIdx;
   logic             ubaHit;
   // stage 0 is loaded on the sampling edge
   logic [2:0]       ackPipe;
   ks10Word_t        rdPipe [3];

   ////////////////////////////////////////
   // window decode
   ////////////////////////////////////////

   assign ubaIdx = busADDR[addrW-ubaAw:addrW-1];

   // I/O space, inside the adapter window
   assign ubaHit = busREQ && busIO &&
                   (busADDR >= ks10Addr_t'(`KS10_UBA_BASE)) &&
                   (busADDR <  ks10Addr_t'(`KS10_UBA_BASE + `KS10_UBA_WORDS));

   ////////////////////////////////////////
   // register file
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < `KS10_UBA_WORDS; i++) begin
            ubaReg[i] <= '0;
         end
      end else if (ubaHit && busWRITE) begin
         ubaReg[ubaIdx] <= busDATA;
      end
   end

   ////////////////////////////////////////
   // slow adapter bus delay
   ////////////////////////////////////////

   // acknowledge shifts one stage per cycle
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         ackPipe <= '0;
      end else begin
         ackPipe <= {ackPipe[1:0], ubaHit};
      end
   end

   // read word travels beside the acknowledge
   always_ff @(posedge clk) begin
      rdPipe[0] <= (ubaHit && !busWRITE) ? ubaReg[ubaIdx] : '0;
      rdPipe[1] <= rdPipe[0];
      rdPipe[2] <= rdPipe[1];
   end

   assign ubaACK  = ackPipe[2];
   // zero outside the acknowledge
   assign ubaDATA = ubaACK ? rdPipe[2] : '0;

endmodule

// ==== verilog/arb.sv ====
/*
 * KS10 bus arbiter
 * acknowledge merge, priority read mux and nonexistent-memory timeout
 */
`timescale 1ns/10ps
`include "ks10_settings.svh"

module arb (
   input  logic               clk,
   input  logic               rstN,
   input  logic               busREQ,
   input  logic               memACK,
   input  logic               consACK,
   input  logic               ubaACK,
   input  ks10Pkg::ks10Word_t memDATA,
   input  ks10Pkg::ks10Word_t consDATA,
   input  ks10Pkg::ks10Word_t ubaDATA,
   output logic               arbACK,
   output ks10Pkg::ks10Word_t arbDATA,
   output logic               nxm
);

   localparam int unsigned cntW = $clog2(`KS10_NXM_TIMEOUT + 1);

   // a request is outstanding
   logic            busy;
   logic [cntW-1:0] nxmCount;

   ////////////////////////////////////////
   // acknowledge merge and data mux
   ////////////////////////////////////////

   assign arbACK = memACK | ubaACK | consACK;

   // memory first, then adapter, then console
   always_comb begin
      if (memACK) begin
         arbDATA = memDATA;
      end else if (ubaACK) begin
         arbDATA = ubaDATA;
      end else if (consACK) begin
         arbDATA = consDATA;
      end else begin
         arbDATA = '0;
      end
   end

   ////////////////////////////////////////
   // nonexistent memory timeout
   ////////////////////////////////////////

   // the sampling edge counts as the first cycle without acknowledge
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         busy     <= 1'b0;
         nxmCount <= '0;
      end else if (busREQ) begin
         busy     <= 1'b1;
         nxmCount <= cntW'(1);
      end else if (arbACK || nxm) begin
         busy     <= 1'b0;
         nxmCount <= '0;
      end else if (busy) begin
         nxmCount <= nxmCount + 1'b1;
      end
   end

   // one cycle, then the request is dropped
   assign nxm = busy && (nxmCount == cntW'(`KS10_NXM_TIMEOUT));

   // responders decode disjoint windows
   ackOneHot: assert property (@(posedge clk) disable iff (!rstN)
      $onehot0({memACK, consACK, ubaACK}))
      else $error("more than one responder acknowledged");

   // new request only once the previous one has ended
   reqIdle: assert property (@(posedge clk) disable iff (!rstN)
      busREQ |-> (!busy || arbACK || nxm))
      else $error("busREQ while a request is outstanding");

endmodule

// ==== verilog/ks10Bus.sv ====
/*
 * KS10 backplane bus
 * request port fanned out to memory, console, adapter and arbiter
 */
`timescale 1ns/10ps

module ks10Bus (
   input  logic               clk,
   input  logic               rstN,
   input  logic               busREQ,
   input  logic               busIO,
   input  logic               busWRITE,
   input  ks10Pkg::ks10Addr_t busADDR,
   input  ks10Pkg::ks10Word_t busDATA,
   output logic               arbACK,
   output ks10Pkg::ks10Word_t arbDATA,
   output logic               nxm
);
   import ks10Pkg::*;

   // responder answers into the arbiter
   logic      memACK;
   logic      consACK;
   logic      ubaACK;
   ks10Word_t memDATA;
   ks10Word_t consDATA;
   ks10Word_t ubaDATA;

   ////////////////////////////////////////
   // responders
   ////////////////////////////////////////

   // each one decodes the request by itself
   memCtrl uMem (
      .clk      (clk),
      .rstN     (rstN),
      .busREQ   (busREQ),
      .busIO    (busIO),
      .busWRITE (busWRITE),
      .busADDR  (busADDR),
      .busDATA  (busDATA),
      .memACK   (memACK),
      .memDATA  (memDATA)
   );

   consRegs uCons (
      .clk      (clk),
      .rstN     (rstN),
      .busREQ   (busREQ),
      .busIO    (busIO),
      .busWRITE (busWRITE),
      .busADDR  (busADDR),
      .busDATA  (busDATA),
      .consACK  (consACK),
      .consDATA (consDATA)
   );

   ubaRegs uUba (
      .clk      (clk),
      .rstN     (rstN),
      .busREQ   (busREQ),
      .busIO    (busIO),
      .busWRITE (busWRITE),
      .busADDR  (busADDR),
      .busDATA  (busDATA),
      .ubaACK   (ubaACK),
      .ubaDATA  (ubaDATA)
   );

   ////////////////////////////////////////
   // arbiter
   ////////////////////////////////////////

   arb uArb (
      .clk      (clk),
      .rstN     (rstN),
      .busREQ   (busREQ),
      .memACK   (memACK),
      .consACK  (consACK),
      .ubaACK   (ubaACK),
      .memDATA  (memDATA),
      .consDATA (consDATA),
      .ubaDATA  (ubaDATA),
      .arbACK   (arbACK),
      .arbDATA  (arbDATA),
      .nxm      (nxm)
   );

endmodule

// ==== tb/ks10BusTb.sv ====
/*
 * KS10 bus testbench
 * drives requests into the bus, predicts each answer and checks it
 */
`timescale 1ns/10ps
`include "ks10_settings.svh"

module ks10BusTb;
   import ks10Pkg::*;

   // test lengths, all counted in requests
   localparam int memN      = 16;
   localparam int mixRounds = 4;
   localparam int nxmN      = 5;
   localparam int latN      = 6;
   localparam int resetCycles = 3;
   localparam int numReqs   = 2 * memN + 3 * `KS10_CONS_WORDS + 2 * `KS10_UBA_WORDS +
                              3 * mixRounds + nxmN + latN;
   localparam int cycleLimit = numReqs * (`KS10_NXM_TIMEOUT + 4) + resetCycles;
   localparam int maxWait   = `KS10_NXM_TIMEOUT + 4;

   logic      clk = 1'b0;
   logic      rstN;
   logic      busREQ;
   logic      busIO;
   logic      busWRITE;
   ks10Addr_t busADDR;
   ks10Word_t busDATA;
   logic      arbACK;
   ks10Word_t arbDATA;
   logic      nxm;

   // model state
   ks10Word_t modelMem [`KS10_MEM_WORDS];
   ks10Word_t modelCons [`KS10_CONS_WORDS];
   ks10Word_t modelUba [`KS10_UBA_WORDS];
   ks10Addr_t memAddrs [$];

   // expected answer of the request in flight
   logic      expAck;
   ks10Word_t expData;
   int        expLat;
   string     curName;

   int        reqCount = 0;
   int        doneCount = 0;
   int        cycleCount = 0;
   int        waitCount = 0;
   logic      waiting = 1'b0;
   logic      reqSeen;
   int        dataErrors = 0;
   int        latErrors = 0;
   int        protoErrors = 0;

   ks10Bus DUT (
      .clk      (clk),
      .rstN     (rstN),
      .busREQ   (busREQ),
      .busIO    (busIO),
      .busWRITE (busWRITE),
      .busADDR  (busADDR),
      .busDATA  (busDATA),
      .arbACK   (arbACK),
      .arbDATA  (arbDATA),
      .nxm      (nxm)
   );

   always #50 clk = ~clk;

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////

   // decode the request, update the model on writes and give the answer
   function automatic void predict(input logic io, input logic write, input ks10Addr_t addr,
                                   input ks10Word_t data, output logic ack,
                                   output ks10Word_t word, output int lat);
      int idx;
      ack  = 1'b1;
      word = '0;
      if (!io && addr < ks10Addr_t'(`KS10_MEM_WORDS)) begin
         idx = int'(addr);
         lat = `KS10_MEM_LAT;
         if (write) modelMem[idx] = data;
         else word = modelMem[idx];
      end else if (io && addr >= ks10Addr_t'(`KS10_CONS_BASE) &&
                   addr < ks10Addr_t'(`KS10_CONS_BASE + `KS10_CONS_WORDS)) begin
         idx = int'(addr - ks10Addr_t'(`KS10_CONS_BASE));
         lat = `KS10_CONS_LAT;
         if (write) modelCons[idx] = data;
         else word = modelCons[idx];
      end else if (io && addr >= ks10Addr_t'(`KS10_UBA_BASE) &&
                   addr < ks10Addr_t'(`KS10_UBA_BASE + `KS10_UBA_WORDS)) begin
         idx = int'(addr - ks10Addr_t'(`KS10_UBA_BASE));
         lat = `KS10_UBA_LAT;
         if (write) modelUba[idx] = data;
         else word = modelUba[idx];
      end else begin
         // nobody decodes it, the arbiter times out
         ack = 1'b0;
         lat = `KS10_NXM_TIMEOUT;
      end
   endfunction

   function automatic ks10Word_t randWord();
      logic [63:0] r;
      r = {$urandom(), $urandom()};
      return r[35:0];
   endfunction

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   // one bus cycle, called on a falling edge
   task automatic busAccess(input logic io, input logic write, input ks10Addr_t addr,
                            input ks10Word_t data, input string name);
      logic      ack;
      ks10Word_t word;
      int        lat;
      predict(io, write, addr, data, ack, word, lat);
      expAck   = ack;
      expData  = word;
      expLat   = lat;
      curName  = name;
      busIO    = io;
      busWRITE = write;
      busADDR  = addr;
      busDATA  = data;
      busREQ   = 1'b1;
      reqCount = reqCount + 1;
      @(negedge clk);
      // strobe lasts one cycle
      busREQ   = 1'b0;
      busWRITE = 1'b0;
      busDATA  = '0;
      wait (doneCount == reqCount);
      @(negedge clk);
   endtask

   ////////////////////////////////////////
   // response checking
   ////////////////////////////////////////

   // marks the edge that sampled a request
   always @(posedge clk) begin
      reqSeen <= rstN && busREQ;
   end

   // outputs change on rising edges, so they are checked on falling ones
   always @(negedge clk) begin
      if (reqSeen) begin
         waiting   = 1'b1;
         waitCount = 1;
      end else if (waiting) begin
         waitCount = waitCount + 1;
      end
      if (waiting && (arbACK || nxm)) begin
         if (expAck) begin
            assert (arbACK && !nxm) else begin
               $display("Error: %s expected an acknowledge but got nxm", curName);
               protoErrors++;
            end
            // write cycles expect a zero word
            assert (!arbACK || arbDATA == expData) else begin
               $display("Error: %s expected %012o actual %012o", curName, expData, arbDATA);
               dataErrors++;
            end
         end else begin
            assert (nxm && !arbACK) else begin
               $display("Error: %s expected nxm but got an acknowledge", curName);
               protoErrors++;
            end
         end
         assert (waitCount == expLat) else begin
            $display("Error: %s latency expected %0d actual %0d", curName, expLat, waitCount);
            latErrors++;
         end
         waiting   = 1'b0;
         doneCount = doneCount + 1;
      end else if (waiting && waitCount > maxWait) begin
         $display("Error: %s got neither acknowledge nor nxm", curName);
         protoErrors++;
         waiting   = 1'b0;
         doneCount = doneCount + 1;
      end else if (!waiting) begin
         assert (!arbACK && !nxm) else begin
            $display("Error: acknowledge or nxm with no request outstanding");
            protoErrors++;
         end
         // read word stays zero on an idle bus
         assert (arbDATA == '0) else begin
            $display("Error: idle after %s expected %012o actual %012o",
                     curName, ks10Word_t'(0), arbDATA);
            dataErrors++;
         end
      end
   end

   // run limit
   always @(posedge clk) begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout after %0d cycles, %0d of %0d requests done",
                  cycleCount, doneCount, numReqs);
         $display("Verification failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial begin
      ks10Addr_t a;
      int        i;
      void'($urandom(32'haeda_a9fe));
      rstN     = 1'b0;
      busREQ   = 1'b0;
      busIO    = 1'b0;
      busWRITE = 1'b0;
      busADDR  = '0;
      busDATA  = '0;
      foreach (modelCons[k]) modelCons[k] = '0;
      foreach (modelUba[k]) modelUba[k] = '0;
      repeat (resetCycles) @(negedge clk);
      rstN = 1'b1;

      // memory write then readback
      for (i = 0; i < memN; i++) begin
         a = ks10Addr_t'($urandom_range(`KS10_MEM_WORDS - 1, 0));
         memAddrs.push_back(a);
         busAccess(1'b0, 1'b1, a, randWord(), $sformatf("mem write %0d", i));
      end
      for (i = 0; i < memN; i++) begin
         busAccess(1'b0, 1'b0, memAddrs[i], '0, $sformatf("mem read %0d", i));
      end

      // console mailboxes read zero, then hold written words
      for (i = 0; i < `KS10_CONS_WORDS; i++) begin
         a = ks10Addr_t'(`KS10_CONS_BASE + i);
         busAccess(1'b1, 1'b0, a, '0, $sformatf("cons reset read %0d", i));
      end
      for (i = 0; i < `KS10_CONS_WORDS; i++) begin
         a = ks10Addr_t'(`KS10_CONS_BASE + i);
         busAccess(1'b1, 1'b1, a, randWord(), $sformatf("cons write %0d", i));
      end
      for (i = 0; i < `KS10_CONS_WORDS; i++) begin
         a = ks10Addr_t'(`KS10_CONS_BASE + i);
         busAccess(1'b1, 1'b0, a, '0, $sformatf("cons read %0d", i));
      end

      // adapter registers, all written, then random reads
      for (i = 0; i < `KS10_UBA_WORDS; i++) begin
         a = ks10Addr_t'(`KS10_UBA_BASE + i);
         busAccess(1'b1, 1'b1, a, randWord(), $sformatf("uba write %0d", i));
      end
      for (i = 0; i < `KS10_UBA_WORDS; i++) begin
         a = ks10Addr_t'(`KS10_UBA_BASE + $urandom_range(`KS10_UBA_WORDS - 1, 0));
         busAccess(1'b1, 1'b0, a, '0, $sformatf("uba read %0d", i));
      end

      // alternating sources
      for (i = 0; i < mixRounds; i++) begin
         a = memAddrs[$urandom_range(memN - 1, 0)];
         busAccess(1'b0, 1'b0, a, '0, $sformatf("mix mem %0d", i));
         a = ks10Addr_t'(`KS10_UBA_BASE + $urandom_range(`KS10_UBA_WORDS - 1, 0));
         busAccess(1'b1, 1'b0, a, '0, $sformatf("mix uba %0d", i));
         a = ks10Addr_t'(`KS10_CONS_BASE + $urandom_range(`KS10_CONS_WORDS - 1, 0));
         busAccess(1'b1, 1'b0, a, '0, $sformatf("mix cons %0d", i));
      end

      // nonexistent memory and unclaimed I/O
      busAccess(1'b0, 1'b0, ks10Addr_t'(`KS10_MEM_WORDS), '0, "nxm top of memory");
      a = ks10Addr_t'($urandom_range(32'h3ffff, `KS10_MEM_WORDS));
      busAccess(1'b0, 1'b0, a, '0, "nxm random memory");
      busAccess(1'b1, 1'b0, 18'o100000, '0, "nxm io low");
      a = ks10Addr_t'(`KS10_CONS_BASE + `KS10_CONS_WORDS);
      busAccess(1'b1, 1'b0, a, '0, "nxm past console");
      a = ks10Addr_t'(`KS10_UBA_BASE + `KS10_UBA_WORDS);
      busAccess(1'b1, 1'b0, a, '0, "nxm past adapter");

      // latency of each responder, with a zero word on writes
      busAccess(1'b0, 1'b1, 18'o000777, randWord(), "latency mem write");
      busAccess(1'b0, 1'b0, 18'o000777, '0, "latency mem read");
      a = ks10Addr_t'(`KS10_CONS_BASE + 1);
      busAccess(1'b1, 1'b1, a, randWord(), "latency cons write");
      busAccess(1'b1, 1'b0, a, '0, "latency cons read");
      a = ks10Addr_t'(`KS10_UBA_BASE + 5);
      busAccess(1'b1, 1'b1, a, randWord(), "latency uba write");
      busAccess(1'b1, 1'b0, a, '0, "latency uba read");

      // bus stays quiet afterwards
      repeat (4) @(negedge clk);
      $display("errors: %0d data, %0d latency, %0d protocol, %0d requests",
               dataErrors, latErrors, protoErrors, doneCount);
      if (dataErrors + latErrors + protoErrors == 0 && doneCount == numReqs) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/ks10Pkg.sv
verilog/memCtrl.sv
verilog/consRegs.sv
verilog/ubaRegs.sv
verilog/arb.sv
verilog/ks10Bus.sv
tb/ks10BusTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the KS10 bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module ks10BusTb -o ks10BusSim

out=$(./obj_dir/ks10BusSim)
echo "$out"

if echo "$out" | grep -q "^Verification passed$"; then
   exit 0
else
   exit 1
fi
